// ==== design/branch_predictor.sv ====
// Combined 2-bit counter predictor and branch target buffer
// Direct mapped, indexed by the low PC bits and tagged with the rest
// Looked up at the current fetch PC, written by branch resolutions from execute
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
  input  logic             clk,
  input  logic             rst,
  input  logic             resolve_valid,   // One cycle pulse per resolved branch
  input  fetch_pkg::addr_t resolve_pc,
  input  logic             resolve_taken,
  input  fetch_pkg::addr_t resolve_target,
  if_id_bus.pred_src       bus,             // Reads pc_curr, drives prediction fields
  output logic             predict_taken
);

  //////////////////////////////
  // Table storage
  //////////////////////////////
  logic                 valid_q  [fetch_pkg::BTB_ENTRIES];
  fetch_pkg::pred_t     cnt_q    [fetch_pkg::BTB_ENTRIES];
  fetch_pkg::btb_tag_t  tag_q    [fetch_pkg::BTB_ENTRIES];   // Payload, no reset
  fetch_pkg::addr_t     target_q [fetch_pkg::BTB_ENTRIES];   // Payload, no reset

  // Saturating counter steps
  function automatic fetch_pkg::pred_t cnt_up(input fetch_pkg::pred_t c);
    return (c == fetch_pkg::PRED_STRONG_T) ? c : c + fetch_pkg::pred_t'(1);
  endfunction

  function automatic fetch_pkg::pred_t cnt_down(input fetch_pkg::pred_t c);
    return (c == fetch_pkg::PRED_STRONG_NT) ? c : c - fetch_pkg::pred_t'(1);
  endfunction

  //////////////////////////////
  // Lookup at fetch PC
  //////////////////////////////
  fetch_pkg::btb_index_t lk_idx;
  fetch_pkg::btb_tag_t   lk_tag;
  logic                  lk_hit;

  assign lk_idx = bus.pc_curr[fetch_pkg::BTB_INDEX_BITS-1:0];
  assign lk_tag = bus.pc_curr[fetch_pkg::ADDR_W-1:fetch_pkg::BTB_INDEX_BITS];
  assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

  // Miss reads as strongly not taken with no target
  assign bus.prediction       = lk_hit ? cnt_q[lk_idx]    : fetch_pkg::pred_t'(0);
  assign bus.predicted_target = lk_hit ? target_q[lk_idx] : fetch_pkg::addr_t'(0);
  assign predict_taken        = lk_hit & cnt_q[lk_idx][fetch_pkg::PRED_W-1];

  //////////////////////////////
  // Update from execute
  //////////////////////////////
  fetch_pkg::btb_index_t up_idx;
  fetch_pkg::btb_tag_t   up_tag;
  logic                  up_hit;
  fetch_pkg::pred_t      up_base;   // Counter before the taken step

  assign up_idx  = resolve_pc[fetch_pkg::BTB_INDEX_BITS-1:0];
  assign up_tag  = resolve_pc[fetch_pkg::ADDR_W-1:fetch_pkg::BTB_INDEX_BITS];
  assign up_hit  = valid_q[up_idx] && (tag_q[up_idx] == up_tag);
  assign up_base = up_hit ? cnt_q[up_idx] : fetch_pkg::PRED_INIT;   // Replaced entry restarts

  // Valid bits and counters
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < fetch_pkg::BTB_ENTRIES; i++) begin
        valid_q[i] <= 1'b0;
        cnt_q[i]   <= fetch_pkg::PRED_INIT;
      end
    end else if (resolve_valid) begin
      if (resolve_taken) begin
        valid_q[up_idx] <= 1'b1;               // Allocate or refresh
        cnt_q[up_idx]   <= cnt_up(up_base);
      end else if (up_hit) begin
        cnt_q[up_idx]   <= cnt_down(cnt_q[up_idx]);
      end
      // Not taken miss leaves the table alone
    end
  end

  // Tags and targets, written on taken only
  always_ff @(posedge clk) begin
    if (resolve_valid && resolve_taken) begin
      tag_q[up_idx]    <= up_tag;
      target_q[up_idx] <= resolve_target;
    end
  end

endmodule

`default_nettype wire

// ==== design/fetch_control.sv ====
// Fetch stage steering
// Folds the hazard stall, the execute redirect and the prediction into
// the next PC source and the IF/ID stall and flush levels
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
  input  logic               stall_req,      // Level from the hazard unit
  input  logic               redirect,       // One cycle pulse from execute
  input  logic               predict_taken,  // Hit with counter upper bit set
  output fetch_pkg::pc_sel_t pc_sel,
  output logic               if_id_stall,
  output logic               if_id_flush
);

  //////////////////////////////
  // Next PC priority
  //////////////////////////////
  always_comb begin
    if (redirect) begin
      pc_sel = fetch_pkg::PC_REDIRECT;   // Mispredict wins over everything
    end else if (stall_req) begin
      pc_sel = fetch_pkg::PC_HOLD;       // Keep refetching the same word
    end else if (predict_taken) begin
      pc_sel = fetch_pkg::PC_PREDICT;
    end else begin
      pc_sel = fetch_pkg::PC_SEQ;
    end
  end

  //////////////////////////////
  // IF/ID register control
  //////////////////////////////

  // A redirect overrides the stall so the PC fields follow the new path
  assign if_id_stall = stall_req & ~redirect;

  // Wrong path word in the fetch slot is turned into a bubble
  assign if_id_flush = redirect;

endmodule

`default_nettype wire

// ==== design/fetch_pkg.sv ====
// Widths, reset values, predictor sizing and the PC source select
// shared by every block of the instruction fetch stage
// Modules use these through scoped names only
`default_nettype none

package fetch_pkg;

  ////////////////////////////////
  // Datapath widths
  ////////////////////////////////
  localparam int ADDR_W = 16;                 // Word addressed instruction space
  localparam int INST_W = 16;
  localparam int PRED_W = 2;                  // 2-bit saturating counter

  typedef logic [ADDR_W-1:0] addr_t;          // Instruction address
  typedef logic [INST_W-1:0] inst_t;          // Instruction word, zero is a NOP
  typedef logic [PRED_W-1:0] pred_t;          // Counter value and decode prediction

  localparam addr_t RESET_PC = '0;            // First fetch after reset

  ////////////////////////////////
  // Predictor table geometry
  ////////////////////////////////
  localparam int BTB_INDEX_BITS = 4;                      // 16 entries
  localparam int BTB_TAG_BITS   = ADDR_W - BTB_INDEX_BITS;
  localparam int BTB_ENTRIES    = 1 << BTB_INDEX_BITS;

  typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;         // Low address bits
  typedef logic [BTB_TAG_BITS-1:0]   btb_tag_t;           // High address bits

  // Counter encodings, upper bit set means taken
  localparam pred_t PRED_STRONG_NT = 2'd0;
  localparam pred_t PRED_WEAK_NT   = 2'd1;
  localparam pred_t PRED_STRONG_T  = 2'd3;
  localparam pred_t PRED_INIT      = PRED_WEAK_NT;        // Fresh entry starts weakly not taken

  ////////////////////////////////
  // Next PC source
  ////////////////////////////////
  typedef enum logic [1:0] {
    PC_REDIRECT,   // Execute stage correction
    PC_HOLD,       // Hazard stall
    PC_PREDICT,    // Predicted taken branch target
    PC_SEQ         // Fall through
  } pc_sel_t;

endpackage

`default_nettype wire

// ==== design/fetch_top.sv ====
// Instruction fetch stage top level
// Drives the instruction memory address, takes the word back in the same
// cycle and hands PC, instruction and prediction to decode through IF/ID
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic             clk,
  input  logic             rst,
  // Hazard unit
  input  logic             stall_req,
  // Execute stage correction
  input  logic             redirect,
  input  fetch_pkg::addr_t redirect_pc,
  // Branch resolution, trains the predictor
  input  logic             resolve_valid,
  input  fetch_pkg::addr_t resolve_pc,
  input  logic             resolve_taken,
  input  fetch_pkg::addr_t resolve_target,
  // Instruction memory, combinational read
  output fetch_pkg::addr_t imem_addr,
  input  fetch_pkg::inst_t imem_data,
  // To decode
  output fetch_pkg::addr_t if_id_pc_curr,
  output fetch_pkg::addr_t if_id_pc_next,
  output fetch_pkg::inst_t if_id_inst,
  output fetch_pkg::pred_t if_id_prediction,
  output fetch_pkg::addr_t if_id_predicted_target
);

  //////////////////////////////
  // Internal wiring
  //////////////////////////////
  if_id_bus fetch_bus ();

  logic               predict_taken;   // Predictor to control
  fetch_pkg::pc_sel_t pc_sel;          // Control to PC
  logic               if_id_stall;
  logic               if_id_flush;

  assign fetch_bus.inst = imem_data;   // Memory word goes straight into the bundle

  //////////////////////////////
  // Instances
  //////////////////////////////
  fetch_control i_fetch_control (
    .stall_req     (stall_req),
    .redirect      (redirect),
    .predict_taken (predict_taken),
    .pc_sel        (pc_sel),
    .if_id_stall   (if_id_stall),
    .if_id_flush   (if_id_flush)
  );

  pc_unit i_pc_unit (
    .clk         (clk),
    .rst         (rst),
    .pc_sel      (pc_sel),
    .redirect_pc (redirect_pc),
    .bus         (fetch_bus.pc_src),
    .imem_addr   (imem_addr)
  );

  branch_predictor i_branch_predictor (
    .clk            (clk),
    .rst            (rst),
    .resolve_valid  (resolve_valid),
    .resolve_pc     (resolve_pc),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .bus            (fetch_bus.pred_src),
    .predict_taken  (predict_taken)
  );

  if_id_pipe_reg i_if_id_pipe_reg (
    .clk                    (clk),
    .rst                    (rst),
    .stall                  (if_id_stall),
    .flush                  (if_id_flush),
    .bus                    (fetch_bus.sink),
    .if_id_pc_curr          (if_id_pc_curr),
    .if_id_pc_next          (if_id_pc_next),
    .if_id_inst             (if_id_inst),
    .if_id_prediction       (if_id_prediction),
    .if_id_predicted_target (if_id_predicted_target)
  );

endmodule

`default_nettype wire

// ==== design/if_id_bus.sv ====
// Fetch side signals feeding the IF/ID register
// PC unit and predictor each drive their own fields, the register reads all
`timescale 1ns/1ps
`default_nettype none

interface if_id_bus;

  fetch_pkg::addr_t pc_curr;            // PC of the word being fetched
  fetch_pkg::addr_t pc_next;            // Fall through PC
  fetch_pkg::inst_t inst;               // Word from instruction memory
  fetch_pkg::pred_t prediction;         // Counter on a hit, zero on a miss
  fetch_pkg::addr_t predicted_target;   // BTB target on a hit, zero on a miss

  // PC register side
  modport pc_src (
    output pc_curr,
    output pc_next,
    input  predicted_target             // Loaded on a predicted taken branch
  );

  // Predictor side, looks up at the current PC
  modport pred_src (
    output prediction,
    output predicted_target,
    input  pc_curr
  );

  // Pipeline register side
  modport sink (
    input pc_curr,
    input pc_next,
    input inst,
    input prediction,
    input predicted_target
  );

endinterface

`default_nettype wire

// ==== design/if_id_pipe_reg.sv ====
// IF/ID pipeline register
// Stall holds every field, flush turns the fetched word into a bubble
// by clearing instruction, prediction and target, PC fields keep loading
`timescale 1ns/1ps
`default_nettype none

module if_id_pipe_reg (
  input  logic             clk,
  input  logic             rst,
  input  logic             stall,    // Hold all fields
  input  logic             flush,    // Clear instruction and prediction fields
  if_id_bus.sink           bus,
  output fetch_pkg::addr_t if_id_pc_curr,
  output fetch_pkg::addr_t if_id_pc_next,
  output fetch_pkg::inst_t if_id_inst,
  output fetch_pkg::pred_t if_id_prediction,
  output fetch_pkg::addr_t if_id_predicted_target
);

  logic load;    // Capture new fetch
  logic clear;   // Bubble insert, also covers reset

  assign load  = ~stall;
  assign clear = flush | rst;   // Flush beats stall for the cleared fields

  //////////////////////////////
  // PC fields
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      if_id_pc_curr <= '0;
      if_id_pc_next <= '0;
    end else if (load) begin
      if_id_pc_curr <= bus.pc_curr;
      if_id_pc_next <= bus.pc_next;
    end
  end

  //////////////////////////////
  // Instruction and prediction
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (clear) begin
      if_id_inst             <= '0;   // NOP
      if_id_prediction       <= '0;
      if_id_predicted_target <= '0;
    end else if (load) begin
      if_id_inst             <= bus.inst;
      if_id_prediction       <= bus.prediction;
      if_id_predicted_target <= bus.predicted_target;
    end
  end

endmodule

`default_nettype wire

// ==== design/pc_unit.sv ====
// Program counter for the fetch stage
// Picks the next fetch address from pc_sel and drives the instruction
// memory address, which is the PC register itself
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
  input  logic               clk,
  input  logic               rst,
  input  fetch_pkg::pc_sel_t pc_sel,       // From fetch_control
  input  fetch_pkg::addr_t   redirect_pc,  // Corrected PC from execute
  if_id_bus.pc_src           bus,          // Publishes PC, reads predicted target
  output fetch_pkg::addr_t   imem_addr
);

  fetch_pkg::addr_t pc_q;       // Current fetch address
  fetch_pkg::addr_t pc_plus1;   // Fall through address
  fetch_pkg::addr_t pc_d;

  assign pc_plus1 = pc_q + fetch_pkg::addr_t'(1);   // Word addressed, so step of one

  //////////////////////////////
  // Next PC mux
  //////////////////////////////
  always_comb begin
    case (pc_sel)
      fetch_pkg::PC_REDIRECT: pc_d = redirect_pc;
      fetch_pkg::PC_HOLD:     pc_d = pc_q;
      fetch_pkg::PC_PREDICT:  pc_d = bus.predicted_target;  // BTB hit, counter says taken
      default:                pc_d = pc_plus1;
    endcase
  end

  //////////////////////////////
  // PC register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= fetch_pkg::RESET_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  // Outputs
  assign imem_addr   = pc_q;       // Memory answers in the same cycle
  assign bus.pc_curr = pc_q;
  assign bus.pc_next = pc_plus1;

endmodule

`default_nettype wire

// ==== dv/fetch_tb.sv ====
// Self-checking testbench for the instruction fetch stage
// Models the instruction memory, runs directed and random stimulus and
// compares every DUT output against a reference model on each cycle
`timescale 1ns/1ps
`default_nettype none

module fetch_tb;

  localparam fetch_pkg::addr_t WIN_BASE = 16'h0200;   // Base of the 32 word random window
  localparam fetch_pkg::addr_t BR_PC    = 16'h0108;   // Trained branch
  localparam fetch_pkg::addr_t BR_TGT   = 16'h0120;

  logic clk;
  logic rst;
  logic stall_req, redirect, resolve_valid, resolve_taken;
  fetch_pkg::addr_t redirect_pc, resolve_pc, resolve_target, imem_addr;
  fetch_pkg::inst_t imem_data;
  fetch_pkg::addr_t if_id_pc_curr, if_id_pc_next, if_id_predicted_target;
  fetch_pkg::inst_t if_id_inst;
  fetch_pkg::pred_t if_id_prediction;

  fetch_pkg::inst_t mem [0:65535];    // Instruction memory model
  logic [31:0] lcg_state = 32'h1487f622;
  int checks = 0;
  int errors = 0;
  int timeouts = 0;

  // Reference state of the PC, the IF/ID fields and the predictor table
  fetch_pkg::addr_t    m_pc, m_curr, m_next, m_tgt_out;
  fetch_pkg::inst_t    m_inst;
  fetch_pkg::pred_t    m_pred;
  logic                m_valid  [16];
  fetch_pkg::pred_t    m_cnt    [16];
  fetch_pkg::btb_tag_t m_tag    [16];
  fetch_pkg::addr_t    m_target [16];

  assign imem_data = mem[imem_addr];   // Combinational read

  initial clk = 1'b0;
  always #2 clk = ~clk;                // 4 ns period

  fetch_top i_dut (
    .clk(clk), .rst(rst), .stall_req(stall_req),
    .redirect(redirect), .redirect_pc(redirect_pc),
    .resolve_valid(resolve_valid), .resolve_pc(resolve_pc),
    .resolve_taken(resolve_taken), .resolve_target(resolve_target),
    .imem_addr(imem_addr), .imem_data(imem_data),
    .if_id_pc_curr(if_id_pc_curr), .if_id_pc_next(if_id_pc_next),
    .if_id_inst(if_id_inst), .if_id_prediction(if_id_prediction),
    .if_id_predicted_target(if_id_predicted_target)
  );

  ///////////////////////////////
  // Helpers
  ///////////////////////////////
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic compare_value(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Applies one clock edge of the fetch stage to the model state
  function automatic void model_step();
    fetch_pkg::btb_index_t li, ui;
    logic hit, uhit, taken;
    fetch_pkg::pred_t base;
    li    = m_pc[3:0];                                  // Lookup at the current PC
    hit   = m_valid[li] && (m_tag[li] == m_pc[15:4]);
    taken = hit && m_cnt[li][1];
    ui    = resolve_pc[3:0];
    uhit  = m_valid[ui] && (m_tag[ui] == resolve_pc[15:4]);
    if (rst) begin
      m_pc      = fetch_pkg::RESET_PC;
      m_curr    = 16'h0;
      m_next    = 16'h0;
      m_inst    = 16'h0;
      m_pred    = 2'd0;
      m_tgt_out = 16'h0;
      for (int i = 0; i < 16; i++) begin
        m_valid[i]  = 1'b0;
        m_cnt[i]    = fetch_pkg::PRED_INIT;
        m_tag[i]    = 12'h0;
        m_target[i] = 16'h0;
      end
    end else begin
      // A redirect clears the IF/ID word but still loads the PC fields
      if (redirect || !stall_req) begin
        m_curr = m_pc;
        m_next = m_pc + 16'h1;
      end
      if (redirect) begin
        m_inst    = 16'h0;
        m_pred    = 2'd0;
        m_tgt_out = 16'h0;
      end else if (!stall_req) begin
        m_inst    = mem[m_pc];
        m_pred    = hit ? m_cnt[li] : 2'd0;
        m_tgt_out = hit ? m_target[li] : 16'h0;
      end
      // Next PC by priority
      if (redirect)        m_pc = redirect_pc;
      else if (stall_req)  m_pc = m_pc;
      else if (taken)      m_pc = m_target[li];
      else                 m_pc = m_pc + 16'h1;
      // Table training
      if (resolve_valid && resolve_taken) begin
        base = uhit ? m_cnt[ui] : fetch_pkg::PRED_INIT;   // Replaced entry restarts
        m_cnt[ui]    = (base == 2'd3) ? base : base + 2'd1;
        m_valid[ui]  = 1'b1;
        m_tag[ui]    = resolve_pc[15:4];
        m_target[ui] = resolve_target;
      end else if (resolve_valid && uhit && m_cnt[ui] != 2'd0) begin
        m_cnt[ui] = m_cnt[ui] - 2'd1;
      end
    end
  endfunction

  // Apply one cycle of inputs at the falling edge
  task automatic drive(input logic st, input logic rd, input fetch_pkg::addr_t rpc,
                       input logic rv, input fetch_pkg::addr_t rspc, input logic rt,
                       input fetch_pkg::addr_t rtgt);
    @(negedge clk);
    stall_req      = st;
    redirect       = rd;
    redirect_pc    = rpc;
    resolve_valid  = rv;
    resolve_pc     = rspc;
    resolve_taken  = rt;
    resolve_target = rtgt;
  endtask

  task automatic drive_idle();
    drive(1'b0, 1'b0, 16'h0, 1'b0, 16'h0, 1'b0, 16'h0);
  endtask

  // Idle until the IF/ID register shows a fetch of address a
  task automatic wait_for_fetch(input fetch_pkg::addr_t a);
    int n;
    n = 0;
    drive_idle();
    while (if_id_pc_curr !== a && n < 40) begin
      drive_idle();
      n++;
    end
    if (if_id_pc_curr !== a) begin
      timeouts++;
      $display("Timeout: address %h never reached IF/ID within 40 cycles", a);
    end
  endtask

  ///////////////////////////////
  // Cycle by cycle comparison
  ///////////////////////////////
  always @(posedge clk) begin
    model_step();   // Inputs are stable since the falling edge
    #1;
    compare_value("imem_addr", imem_addr, m_pc);
    compare_value("if_id_pc_curr", if_id_pc_curr, m_curr);
    compare_value("if_id_pc_next", if_id_pc_next, m_next);
    compare_value("if_id_inst", if_id_inst, m_inst);
    compare_value("if_id_prediction", {14'h0, if_id_prediction}, {14'h0, m_pred});
    compare_value("if_id_predicted_target", if_id_predicted_target, m_tgt_out);
  end

  ///////////////////////////////
  // Stimulus
  ///////////////////////////////
  initial begin
    logic [31:0] r1, r2;
    logic [16:0] a;
    fetch_pkg::addr_t held_addr;
    fetch_pkg::inst_t held_inst;
    for (a = 17'h0; a < 17'h10000; a++) begin
      r1 = lcg_next();
      mem[a[15:0]] = r1[31:16];
    end
    rst            = 1'b1;
    stall_req      = 1'b0;
    redirect       = 1'b0;
    redirect_pc    = 16'h0;
    resolve_valid  = 1'b0;
    resolve_pc     = 16'h0;
    resolve_taken  = 1'b0;
    resolve_target = 16'h0;
    repeat (16) @(posedge clk);   // Reset spans 16 rising edges
    @(negedge clk);
    rst = 1'b0;

    // Straight line fetch
    repeat (20) drive_idle();
    compare_value("seq inst", if_id_inst, mem[if_id_pc_curr]);
    compare_value("seq pc_next", if_id_pc_next, if_id_pc_curr + 16'h1);

    // Stall holds address and IF/ID
    drive(1'b1, 1'b0, 16'h0, 1'b0, 16'h0, 1'b0, 16'h0);
    held_addr = imem_addr;
    held_inst = if_id_inst;
    repeat (5) begin
      drive(1'b1, 1'b0, 16'h0, 1'b0, 16'h0, 1'b0, 16'h0);
      compare_value("stall addr", imem_addr, held_addr);
      compare_value("stall inst", if_id_inst, held_inst);
    end

    // Redirect alone turns the fetch slot into a bubble
    drive(1'b0, 1'b1, 16'h0030, 1'b0, 16'h0, 1'b0, 16'h0);
    drive_idle();
    compare_value("redirect addr", imem_addr, 16'h0030);
    compare_value("redirect bubble", if_id_inst, 16'h0);
    repeat (3) drive_idle();

    // Two taken resolutions saturate the counter
    drive(1'b0, 1'b0, 16'h0, 1'b1, BR_PC, 1'b1, BR_TGT);
    drive(1'b0, 1'b0, 16'h0, 1'b1, BR_PC, 1'b1, BR_TGT);
    drive(1'b0, 1'b1, BR_PC, 1'b0, 16'h0, 1'b0, 16'h0);
    wait_for_fetch(BR_PC);
    compare_value("trained prediction", {14'h0, if_id_prediction}, 16'h3);
    compare_value("trained target", if_id_predicted_target, BR_TGT);
    compare_value("predicted fetch", imem_addr, BR_TGT);

    // Redirect under stall while the trained branch sits in the fetch slot
    drive(1'b0, 1'b1, BR_PC, 1'b0, 16'h0, 1'b0, 16'h0);
    drive(1'b1, 1'b1, 16'h0040, 1'b0, 16'h0, 1'b0, 16'h0);
    drive(1'b1, 1'b0, 16'h0, 1'b0, 16'h0, 1'b0, 16'h0);
    compare_value("stalled redirect addr", imem_addr, 16'h0040);
    compare_value("stalled redirect pc", if_id_pc_curr, BR_PC);
    compare_value("stalled redirect bubble", if_id_inst, 16'h0);
    compare_value("stalled redirect prediction", {14'h0, if_id_prediction}, 16'h0);
    compare_value("stalled redirect target", if_id_predicted_target, 16'h0);
    repeat (3) drive_idle();

    // Two not taken resolutions bring the counter from 3 to 1 so fetch falls through
    drive(1'b0, 1'b0, 16'h0, 1'b1, BR_PC, 1'b0, 16'h0);
    drive(1'b0, 1'b0, 16'h0, 1'b1, BR_PC, 1'b0, 16'h0);
    drive(1'b0, 1'b1, BR_PC, 1'b0, 16'h0, 1'b0, 16'h0);
    wait_for_fetch(BR_PC);
    compare_value("untrained prediction", {14'h0, if_id_prediction}, 16'h1);
    compare_value("fall through fetch", imem_addr, BR_PC + 16'h1);

    // Random mix inside the window
    drive(1'b0, 1'b1, WIN_BASE, 1'b0, 16'h0, 1'b0, 16'h0);
    repeat (400) begin
      r1 = lcg_next();
      r2 = lcg_next();
      drive(r1[31:30] == 2'b00,                      // Stall about a quarter of cycles
            r1[29:27] == 3'b000,                     // Redirect one in eight
            WIN_BASE + {11'h0, r2[31:27]},
            r1[26:25] == 2'b00,                      // Resolution one in four
            WIN_BASE + {11'h0, r2[25:21]},
            r1[24] | r1[23],                         // Mostly taken
            WIN_BASE + {11'h0, r2[19:15]});
    end
    repeat (4) drive_idle();

    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/fetch_pkg.sv
design/if_id_bus.sv
design/fetch_control.sv
design/pc_unit.sv
design/branch_predictor.sv
design/if_id_pipe_reg.sv
design/fetch_top.sv
dv/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the fetch stage testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing -f filelist.f --top-module fetch_tb \
    --Mdir obj_dir -o fetch_sim \
  && ./obj_dir/fetch_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log

grep -q "^Testbench passed$" sim.log && exit 0 || exit 1
